// ==== Bender.yml ====
package:
  name: serial_8b10b_link

sources:
  - source/link_8b10b_pkg.sv
  - source/byte_if.sv
  - source/tx_byte_fifo.sv
  - source/tx_8b10b_serializer.sv
  - source/rx_8b10b_shift_decoder.sv
  - source/serial_8b10b_link.sv
  - target: test
    files:
      - tests/serial_8b10b_link_chk.sv
      - tests/serial_8b10b_link_tb.sv

// ==== build.f ====
source/link_8b10b_pkg.sv
source/byte_if.sv
source/tx_byte_fifo.sv
source/tx_8b10b_serializer.sv
source/rx_8b10b_shift_decoder.sv
source/serial_8b10b_link.sv
tests/serial_8b10b_link_chk.sv
tests/serial_8b10b_link_tb.sv

// ==== source/byte_if.sv ====
`default_nettype none

// FIFO head handoff to the serializer
// Data and k are meaningful whenever empty is low
interface byte_if;

  logic [7:0] data;
  logic       k;
  logic       empty;
  // One-cycle strobe, never raised while empty
  logic       pop;

  // FIFO side presents the head entry
  modport fifo (
    output data,
    output k,
    output empty,
    input  pop
  );

  // Serializer side consumes it
  modport ser (
    input  data,
    input  k,
    input  empty,
    output pop
  );

endinterface

`default_nettype wire

// ==== source/link_8b10b_pkg.sv ====
`default_nettype none

package link_8b10b_pkg;

  // ========================================================================
  // Code word and control constants
  // ========================================================================

  // Ten-bit code word, bit 0 holds the a bit and goes on the line first
  // Sub-block fields also keep their first bit at index 0
  typedef union packed {
    logic [9:0] word;
    struct packed {
      logic [3:0] fghj;
      logic [5:0] abcdei;
    } blk;
  } code10_u;

  // Idle comma and the K code the comma aligner cannot tolerate
  localparam logic [7:0] K28_5_C = 8'hBC;
  localparam logic [7:0] K28_7_C = 8'hFC;

  // Tables below are in written order, a (or f) as the MSB
  // RD- column only, the RD+ form is derived by the functions
  localparam logic [5:0] K28_6B_C = 6'b001111;

  localparam logic [5:0] D6_NEG_C [0:31] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001,
    6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100,
    6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010,
    6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110,
    6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // Data 3b/4b, entry 7 is the primary P7 form
  localparam logic [3:0] D4_NEG_C [0:7] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };

  // Control 3b/4b, every entry alternates with disparity
  localparam logic [3:0] K4_NEG_C [0:7] = '{
    4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
  };

  // ========================================================================
  // Helpers
  // ========================================================================

  function automatic logic [5:0] rev6(input logic [5:0] v);
    logic [5:0] r;
    for (int i = 0; i < 6; i++)
      r[i] = v[5-i];
    return r;
  endfunction

  function automatic logic [3:0] rev4(input logic [3:0] v);
    logic [3:0] r;
    for (int i = 0; i < 4; i++)
      r[i] = v[3-i];
    return r;
  endfunction

  // K.28.0 to K.28.6 plus the four K.x.7 codes
  function automatic logic is_legal_k(input logic [7:0] b);
    return ((b[4:0] == 5'd28) && (b[7:5] != 3'd7)) ||
           (b == 8'hF7) || (b == 8'hFB) || (b == 8'hFD) || (b == 8'hFE);
  endfunction

  // ========================================================================
  // Encoder
  // ========================================================================

  function automatic code10_u encode_8b10b(
    input  logic [7:0] data,
    input  logic       k,
    input  logic       rd_in,
    output logic       rd_out
  );
    code10_u    cw;
    logic [5:0] c6;
    logic [3:0] c4;
    logic [4:0] x;
    logic [2:0] y;
    logic       rd6;
    logic       alt7;
    x = data[4:0];
    y = data[7:5];
    // 5b/6b, unbalanced codes and D.07 flip at RD+
    c6 = (k && (x == 5'd28)) ? K28_6B_C : D6_NEG_C[x];
    if (rd_in && (($countones(c6) != 3) || (x == 5'd7)))
      c6 = ~c6;
    rd6 = ($countones(c6) == 3) ? rd_in : ~rd_in;
    // A7 avoids a run of five across e i f g h
    alt7 = (!rd6 && ((x == 5'd17) || (x == 5'd18) || (x == 5'd20))) ||
           (rd6 && ((x == 5'd11) || (x == 5'd13) || (x == 5'd14)));
    if (k)
      c4 = K4_NEG_C[y];
    else if ((y == 3'd7) && alt7)
      c4 = 4'b0111;
    else
      c4 = D4_NEG_C[y];
    if (rd6 && (k || ($countones(c4) != 2) || (y == 3'd3)))
      c4 = ~c4;
    rd_out = ($countones(c4) == 2) ? rd6 : ~rd6;
    cw.blk.abcdei = rev6(c6);
    cw.blk.fghj   = rev4(c4);
    return cw;
  endfunction

  // ========================================================================
  // Decoder
  // ========================================================================

  // A form that matches only the other disparity still decodes
  // but raises rd_err, a missing code raises code_err
  function automatic logic [7:0] decode_8b10b(
    input  code10_u cw,
    input  logic    rd_in,
    output logic    k,
    output logic    rd_out,
    output logic    code_err,
    output logic    rd_err
  );
    logic [5:0] c6;
    logic [5:0] pos6;
    logic [3:0] c4;
    logic [3:0] neg4;
    logic [3:0] pos4;
    logic [4:0] x;
    logic [2:0] y;
    logic       k28;
    logic       hit6;
    logic       good6;
    logic       hit4;
    logic       good4;
    logic       rd6;
    c6    = rev6(cw.blk.abcdei);
    c4    = rev4(cw.blk.fghj);
    x     = '0;
    y     = '0;
    k     = 1'b0;
    // 6b sub-block, K.28 is outside the data table
    k28   = (c6 == K28_6B_C) || (c6 == ~K28_6B_C);
    hit6  = k28;
    good6 = (c6 == (rd_in ? ~K28_6B_C : K28_6B_C));
    if (k28)
      x = 5'd28;
    for (int i = 0; i < 32; i++)
    begin
      pos6 = (($countones(D6_NEG_C[i]) != 3) || (i == 7)) ? ~D6_NEG_C[i] : D6_NEG_C[i];
      if (c6 == (rd_in ? pos6 : D6_NEG_C[i]))
      begin
        x     = 5'(i);
        hit6  = 1'b1;
        good6 = 1'b1;
      end
      else if (c6 == (rd_in ? D6_NEG_C[i] : pos6))
      begin
        x    = 5'(i);
        hit6 = 1'b1;
      end
    end
    if ($countones(c6) == 3)
      rd6 = rd_in;
    else
      rd6 = ($countones(c6) > 3);
    // 4b sub-block, A7 form also carries the K.x.7 codes
    hit4  = 1'b0;
    good4 = 1'b0;
    if ((c4 == 4'b0111) || (c4 == 4'b1000))
    begin
      y     = 3'd7;
      hit4  = 1'b1;
      good4 = (c4 == (rd6 ? 4'b1000 : 4'b0111));
      k     = (x == 5'd23) || (x == 5'd27) || (x == 5'd29) || (x == 5'd30);
    end
    else
    begin
      // K.28.1 and K.28.6 share patterns, disparity picks one
      for (int j = 0; j < 8; j++)
      begin
        neg4 = k28 ? K4_NEG_C[j] : D4_NEG_C[j];
        pos4 = (k28 || ($countones(neg4) != 2) || (j == 3)) ? ~neg4 : neg4;
        if (c4 == (rd6 ? pos4 : neg4))
        begin
          y     = 3'(j);
          hit4  = 1'b1;
          good4 = 1'b1;
        end
        else if (!good4 && (c4 == (rd6 ? neg4 : pos4)))
        begin
          y    = 3'(j);
          hit4 = 1'b1;
        end
      end
    end
    k        = k | k28;
    rd_out   = ($countones(c4) == 2) ? rd6 : ($countones(c4) > 2);
    code_err = ~hit6 | ~hit4;
    rd_err   = (hit6 & ~good6) | (hit4 & ~good4);
    return {y, x};
  endfunction

endpackage

`default_nettype wire

// ==== source/rx_8b10b_shift_decoder.sv ====
`default_nettype none

module rx_8b10b_shift_decoder
  import link_8b10b_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       data_i,
  output logic [7:0] data_o,
  output logic       k_o,
  output logic       v_o,
  output logic       frame_align_o
);

  // Low seven bits a..f of K.28.1 or K.28.5, either polarity
  localparam logic [6:0] COMMA_NEG_C = 7'b1111100;
  localparam logic [6:0] COMMA_POS_C = 7'b0000011;
  // Counter parks here until the first comma
  localparam logic [3:0] CNT_IDLE_C  = 4'd15;

  code10_u    shift_q;
  logic       comma_neg;
  logic       comma_pos;
  logic [3:0] cnt_q;
  logic       frame_recv;
  logic       rd_q;
  logic       dec_rd;
  logic       dec_code_err;
  logic       dec_rd_err;

  // ========================================================================
  // Input shift register
  // ========================================================================

  // New bit enters at the top, so a full word ends with a at bit 0
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      shift_q <= '0;
    else
      shift_q.word <= {data_i, shift_q.word[9:1]};
  end

  // ========================================================================
  // Comma detection and frame counter
  // ========================================================================

  // RD- comma seen means the sender moved to RD+, and the reverse
  assign comma_neg     = (shift_q.word[6:0] == COMMA_NEG_C);
  assign comma_pos     = (shift_q.word[6:0] == COMMA_POS_C);
  assign frame_align_o = comma_neg | comma_pos;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cnt_q <= CNT_IDLE_C;
    else if (frame_align_o || frame_recv)
      cnt_q <= '0;
    else if (cnt_q != CNT_IDLE_C)
      cnt_q <= cnt_q + 4'd1;
  end

  // Ten cycles after each alignment a whole word sits in the register
  assign frame_recv = (cnt_q == 4'd9);

  // ========================================================================
  // Decode and disparity tracking
  // ========================================================================

  always_comb
  begin
    data_o = decode_8b10b(shift_q, rd_q, k_o, dec_rd, dec_code_err, dec_rd_err);
  end

  // Bad words are dropped silently
  assign v_o = frame_recv & ~(dec_code_err | dec_rd_err);

  // Comma polarity seeds the disparity, good frames advance it
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rd_q <= 1'b0;
    else if (frame_align_o)
      rd_q <= comma_neg;
    else if (v_o)
      rd_q <= dec_rd;
  end

endmodule

`default_nettype wire

// ==== source/serial_8b10b_link.sv ====
`default_nettype none

module serial_8b10b_link #(
  parameter int DEPTH_P = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic [7:0] tx_data_i,
  input  logic       tx_k_i,
  input  logic       tx_push_i,
  input  logic       rx_i,
  output logic       tx_full_o,
  output logic       tx_o,
  output logic [7:0] rx_data_o,
  output logic       rx_k_o,
  output logic       rx_v_o,
  output logic       rx_frame_align_o
);

  // Head of the byte FIFO as seen by the serializer
  byte_if fifo_ser_if ();

  // ========================================================================
  // Transmit path
  // ========================================================================

  tx_byte_fifo #(
    .DEPTH_P (DEPTH_P)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (tx_push_i),
    .data_i  (tx_data_i),
    .k_i     (tx_k_i),
    .full_o  (tx_full_o),
    .rd      (fifo_ser_if)
  );

  tx_8b10b_serializer u_ser (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rd      (fifo_ser_if),
    .tx_o    (tx_o)
  );

  // ========================================================================
  // Receive path
  // ========================================================================

  rx_8b10b_shift_decoder u_dec (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .data_i        (rx_i),
    .data_o        (rx_data_o),
    .k_o           (rx_k_o),
    .v_o           (rx_v_o),
    .frame_align_o (rx_frame_align_o)
  );

endmodule

`default_nettype wire

// ==== source/tx_8b10b_serializer.sv ====
`default_nettype none

module tx_8b10b_serializer
  import link_8b10b_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  byte_if.ser  rd,
  output logic tx_o
);

  // K.28.5 RD- as a flat word, a bit at index 0
  localparam logic [9:0] IDLE_NEG_C = 10'b0101_111100;

  logic [3:0] bit_cnt_q;
  logic [9:0] shift_q;
  // Disparity after the symbol now on the line
  logic       rd_q;
  logic       last_bit;
  logic [7:0] next_data;
  logic       next_k;
  code10_u    next_cw;
  logic       next_rd;

  // ========================================================================
  // Symbol boundary and next word selection
  // ========================================================================

  assign last_bit = (bit_cnt_q == 4'd9);

  // Take the head if there is one, else fill with an idle comma
  assign rd.pop    = last_bit & ~rd.empty;
  assign next_data = rd.empty ? K28_5_C : rd.data;
  assign next_k    = rd.empty | rd.k;

  always_comb
  begin
    next_cw = encode_8b10b(next_data, next_k, rd_q, next_rd);
  end

  // ========================================================================
  // Bit counter, shifter and running disparity
  // ========================================================================

  // Link starts at RD-, the reset comma is the RD- form
  // and leaves the running disparity at RD+
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bit_cnt_q <= '0;
      shift_q   <= IDLE_NEG_C;
      rd_q      <= 1'b1;
    end
    else if (last_bit)
    begin
      bit_cnt_q <= '0;
      shift_q   <= next_cw.word;
      rd_q      <= next_rd;
    end
    else
    begin
      bit_cnt_q <= bit_cnt_q + 4'd1;
      // LSB first
      shift_q   <= {1'b0, shift_q[9:1]};
    end
  end

  assign tx_o = shift_q[0];

endmodule

`default_nettype wire

// ==== source/tx_byte_fifo.sv ====
`default_nettype none

module tx_byte_fifo #(
  parameter int DEPTH_P = 8
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       push_i,
  input  logic [7:0] data_i,
  input  logic       k_i,
  output logic       full_o,
  byte_if.fifo       rd
);

  // Index width, pointers carry one extra wrap bit
  localparam int AW_C = $clog2(DEPTH_P);

  // Entry is {k, data}
  logic [8:0]    mem_q [DEPTH_P];
  logic [AW_C:0] wr_ptr_q;
  logic [AW_C:0] rd_ptr_q;
  logic          wr_en;

  // ========================================================================
  // Status
  // ========================================================================

  // Same index, different wrap bit means a full lap ahead
  assign full_o   = (wr_ptr_q[AW_C] != rd_ptr_q[AW_C]) &&
                    (wr_ptr_q[AW_C-1:0] == rd_ptr_q[AW_C-1:0]);
  assign rd.empty = (wr_ptr_q == rd_ptr_q);

  // Push while full is dropped
  assign wr_en = push_i & ~full_o;

  // ========================================================================
  // Storage and pointers
  // ========================================================================

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      mem_q <= '{default: '0};
    else if (wr_en)
      mem_q[wr_ptr_q[AW_C-1:0]] <= {k_i, data_i};
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      // Serializer only pops a valid head
      if (rd.pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  // Head entry straight from the store
  assign rd.data = mem_q[rd_ptr_q[AW_C-1:0]][7:0];
  assign rd.k    = mem_q[rd_ptr_q[AW_C-1:0]][8];

endmodule

`default_nettype wire

// ==== tests/serial_8b10b_link_chk.sv ====
`default_nettype none

// Protocol checks on the FIFO handoff and the receive shift register
module serial_8b10b_link_chk
  import link_8b10b_pkg::*;
#(
  parameter int DEPTH_P = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     full_i,
  input  logic                     empty_i,
  input  logic [$clog2(DEPTH_P):0] wr_ptr_i,
  input  logic [$clog2(DEPTH_P):0] rd_ptr_i,
  input  logic [9:0]               dec_word_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int fail_cnt = 0;

  // True when the word is a K.28.7 form that is legal at this disparity
  function automatic logic is_k28_7(input logic [9:0] word, input logic rd);
    logic [7:0] b;
    logic       k;
    logic       rd_next;
    logic       code_err;
    logic       rd_err;
    b = decode_8b10b(word, rd, k, rd_next, code_err, rd_err);
    return k && (b == K28_7_C) && !code_err && !rd_err;
  endfunction

  // ========================================================================
  // FIFO handoff
  // ========================================================================

  // Write pointer must not move while full
  push_while_full_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    full_i |=> (wr_ptr_i == $past(wr_ptr_i))
  ) else
  begin
    $error("FIFO accepted a push while full");
    fail_cnt++;
  end

  // Read pointer must not move while empty
  pop_while_empty_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    empty_i |=> (rd_ptr_i == $past(rd_ptr_i))
  ) else
  begin
    $error("serializer popped an empty FIFO");
    fail_cnt++;
  end

  // ========================================================================
  // Receive shift register
  // ========================================================================

  // K.28.7 would let the aligner lock on a false comma
  no_k28_7_a: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !is_k28_7(dec_word_i, 1'b0) && !is_k28_7(dec_word_i, 1'b1)
  ) else
  begin
    $error("decoder shift register holds a K.28.7 code");
    fail_cnt++;
  end

endmodule

// Attached to the top level with probes into the FIFO and decoder
bind serial_8b10b_link serial_8b10b_link_chk #(
  .DEPTH_P (DEPTH_P)
) u_link_chk (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .full_i     (tx_full_o),
  .empty_i    (fifo_ser_if.empty),
  .wr_ptr_i   (u_fifo.wr_ptr_q),
  .rd_ptr_i   (u_fifo.rd_ptr_q),
  .dec_word_i (u_dec.shift_q)
);

`default_nettype wire

// ==== tests/serial_8b10b_link_tb.sv ====
`default_nettype none

module serial_8b10b_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH_C      = 8;
  localparam int BURST_C      = 200;
  localparam int MIXED_C      = 150;
  localparam int TOTAL_PUSH_C = BURST_C + MIXED_C + 3 * DEPTH_C;
  // Ten bit times per entry at 4 ns plus slack for idle phases
  localparam int WATCHDOG_NS_C = TOTAL_PUSH_C * 10 * 4 + 2000;
  localparam int DRAIN_LIMIT_C = (DEPTH_C + 4) * 10;
  localparam logic [7:0] IDLE_BYTE_C = 8'hBC;
  localparam logic [7:0] K28_1_C     = 8'h3C;

  // Legal control codes other than K.28.5
  localparam logic [7:0] K_TAB_C [10] = '{
    8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hDC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
  };

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic [7:0] tx_data_i;
  logic       tx_k_i;
  logic       tx_push_i;
  logic       rx_i;
  logic       tx_full_o;
  logic       tx_o;
  logic [7:0] rx_data_o;
  logic       rx_k_o;
  logic       rx_v_o;
  logic       rx_frame_align_o;

  // Line source select between loopback and a forced level
  logic       loop_en;
  logic       rx_force;
  // Set while rx_i is held low
  logic       quiet_line;

  logic [31:0] lcg_state;
  logic [8:0]  exp_q [$];
  int          err_cnt;
  int          test_cnt;
  int          fail_cnt;
  int          idle_cnt;
  int          recv_cnt;
  int          full_hits;

  always #2 clk_i = ~clk_i;

  assign rx_i = loop_en ? tx_o : rx_force;

  serial_8b10b_link #(
    .DEPTH_P (DEPTH_C)
  ) u_serial_8b10b_link (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .tx_data_i        (tx_data_i),
    .tx_k_i           (tx_k_i),
    .tx_push_i        (tx_push_i),
    .rx_i             (rx_i),
    .tx_full_o        (tx_full_o),
    .tx_o             (tx_o),
    .rx_data_o        (rx_data_o),
    .rx_k_o           (rx_k_o),
    .rx_v_o           (rx_v_o),
    .rx_frame_align_o (rx_frame_align_o)
  );

  // ========================================================================
  // Stimulus helpers
  // ========================================================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Pushes only while not full and in dense mode on every free cycle
  task automatic send_entries(input int count, input bit with_k, input bit dense);
    int          sent;
    logic [31:0] r;
    logic [7:0]  b;
    logic        k;
    sent = 0;
    while (sent < count)
    begin
      @(posedge clk_i);
      #1;
      tx_push_i = 1'b0;
      r = lcg_next();
      if (tx_full_o)
        full_hits++;
      else if (dense || r[16])
      begin
        // K.28.1 at fixed spots acts as a second comma
        if (with_k && ((sent % 25) == 12))
        begin
          b = K28_1_C;
          k = 1'b1;
        end
        else if (with_k && (r[10:8] == 3'd0))
        begin
          b = K_TAB_C[r[23:17] % 10];
          k = 1'b1;
        end
        else
        begin
          b = r[31:24];
          k = 1'b0;
        end
        tx_data_i = b;
        tx_k_i    = k;
        tx_push_i = 1'b1;
        exp_q.push_back({k, b});
        sent++;
      end
    end
    @(posedge clk_i);
    #1;
    tx_push_i = 1'b0;
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while ((exp_q.size() != 0) && (cyc < DRAIN_LIMIT_C))
    begin
      @(posedge clk_i);
      cyc++;
    end
    assert (exp_q.size() == 0)
    else
    begin
      $display("timed out with %0d sent entries never received", exp_q.size());
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int start_err);
    test_cnt++;
    if (err_cnt != start_err)
      fail_cnt++;
    $display("test %0d %s: %s with %0d errors", test_cnt, name,
             (err_cnt == start_err) ? "ok" : "failed", err_cnt - start_err);
  endtask

  // ========================================================================
  // Receive monitor and reference queue
  // ========================================================================

  // Outputs are sampled at the falling edge where they are stable
  always @(negedge clk_i)
  begin : monitor
    logic [8:0] head;
    if (rst_n_i && rx_v_o)
    begin
      assert (!quiet_line)
      else
      begin
        $display("valid pulse seen while rx_i was held at zero");
        err_cnt++;
      end
      if (quiet_line)
        ;
      else if (rx_k_o && (rx_data_o == IDLE_BYTE_C))
        idle_cnt++;
      else if (exp_q.size() == 0)
      begin
        $display("received an entry that was never sent, data 0x%02h", rx_data_o);
        err_cnt++;
      end
      else
      begin
        head = exp_q.pop_front();
        recv_cnt++;
        assert (rx_data_o == head[7:0])
        else
        begin
          $display("error rx_data_o expected 0x%02h actual 0x%02h", head[7:0], rx_data_o);
          err_cnt++;
        end
        assert (rx_k_o == head[8])
        else
        begin
          $display("error rx_k_o expected 0x%0h actual 0x%0h", head[8], rx_k_o);
          err_cnt++;
        end
      end
    end
  end

  // ========================================================================
  // Tests
  // ========================================================================

  // Idle line carries commas every ten bits and nothing else
  task automatic run_idle_check();
    int start_err;
    int start_idle;
    int last_align;
    int aligns;
    start_err  = err_cnt;
    start_idle = idle_cnt;
    last_align = -1;
    aligns     = 0;
    for (int cyc = 0; cyc < 60; cyc++)
    begin
      @(negedge clk_i);
      if (rx_frame_align_o)
      begin
        if (last_align >= 0)
        begin
          assert ((cyc - last_align) == 10)
          else
          begin
            $display("alignment pulses %0d cycles apart instead of 10", cyc - last_align);
            err_cnt++;
          end
        end
        last_align = cyc;
        aligns++;
      end
    end
    assert (aligns >= 4)
    else
    begin
      $display("only %0d alignment pulses seen on an idle line", aligns);
      err_cnt++;
    end
    assert ((idle_cnt - start_idle) >= 3)
    else
    begin
      $display("too few idle commas decoded on an idle line");
      err_cnt++;
    end
    report_test("idle commas", start_err);
  endtask

  task automatic run_traffic(input string name, input int count, input bit with_k,
                             input bit dense);
    int start_err;
    int start_recv;
    int start_full;
    start_err  = err_cnt;
    start_recv = recv_cnt;
    start_full = full_hits;
    send_entries(count, with_k, dense);
    wait_drain();
    assert ((recv_cnt - start_recv) == count)
    else
    begin
      $display("received %0d entries out of %0d sent", recv_cnt - start_recv, count);
      err_cnt++;
    end
    // Back-pressure run has to hit the full level at least once
    if (dense)
    begin
      assert (full_hits != start_full)
      else
      begin
        $display("FIFO never reported full during back-pressure");
        err_cnt++;
      end
    end
    report_test(name, start_err);
  endtask

  // Line held low after lock so no all-zero word may decode
  task automatic run_forced_zero();
    int start_err;
    int cyc;
    start_err = err_cnt;
    cyc = 0;
    do
    begin
      @(posedge clk_i);
      #1;
      cyc++;
    end
    while (!rx_frame_align_o && (cyc < 40));
    assert (rx_frame_align_o)
    else
    begin
      $display("no comma alignment seen before forcing rx_i low");
      err_cnt++;
    end
    loop_en  = 1'b0;
    rx_force = 1'b0;
    // The comma frame itself may still be valid this cycle
    @(posedge clk_i);
    #1;
    quiet_line = 1'b1;
    repeat (60) @(posedge clk_i);
    report_test("forced zero line", start_err);
  endtask

  // ========================================================================
  // Main sequence and watchdog
  // ========================================================================

  initial
  begin
    rst_n_i    = 1'b0;
    tx_data_i  = '0;
    tx_k_i     = 1'b0;
    tx_push_i  = 1'b0;
    loop_en    = 1'b1;
    rx_force   = 1'b0;
    quiet_line = 1'b0;
    lcg_state  = 32'h786d_ac52;
    err_cnt    = 0;
    test_cnt   = 0;
    fail_cnt   = 0;
    idle_cnt   = 0;
    recv_cnt   = 0;
    full_hits  = 0;
    repeat (8) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    run_idle_check();
    run_traffic("data burst", BURST_C, 1'b0, 1'b0);
    run_traffic("data and control mix", MIXED_C, 1'b1, 1'b0);
    run_traffic("back-pressure", 3 * DEPTH_C, 1'b0, 1'b1);
    run_forced_zero();

    $display("summary: %0d tests, %0d failed, %0d errors, %0d assert fails, %0d checked",
             test_cnt, fail_cnt, err_cnt, u_serial_8b10b_link.u_link_chk.fail_cnt,
             recv_cnt);
    if ((err_cnt == 0) && (u_serial_8b10b_link.u_link_chk.fail_cnt == 0))
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS_C);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS_C);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
